// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_controller
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= STATUS: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== compile.f ====
rtl/i3c_ctrl_pkg.sv
rtl/bus_state_if.sv
rtl/line_filter.sv
rtl/bus_monitor.sv
rtl/configuration.sv
rtl/addr_receiver.sv
rtl/controller.sv
dv/controller_chk.sv
dv/tb_controller.sv

// ==== dv/controller_chk.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Protocol checker bound to the controller top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module controller_chk (
  input logic clk_i,
  input logic rst_n_i,
  input logic sda_i,
  input logic start_i,
  input logic stop_i,
  input logic addr_valid_i
);

  start_stop_exclusive: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) !(start_i && stop_i)
  ) else $error("START and STOP reported in the same cycle");

  // One report per address byte
  addr_valid_single: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) addr_valid_i |=> !addr_valid_i
  ) else $error("bus_addr_valid_o high for two cycles in a row");

  sda_released_in_reset: assert property (
    @(posedge clk_i) !rst_n_i |-> sda_i
  ) else $error("sda_o driven low during reset");

endmodule

bind controller controller_chk u_controller_chk (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .sda_i        (sda_o),
  .start_i      (bus_start_o),
  .stop_i       (bus_stop_o),
  .addr_valid_i (bus_addr_valid_o)
);

// ==== dv/tb_controller.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench for the I3C target address controller
// Drives SCL/SDA and register writes, checks strobes and ACK
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module tb_controller;

  localparam int unsigned phase_len   = 20;
  localparam int unsigned cycle_limit = 20000;

  logic                              clk;
  logic                              rst_n;
  logic                              scl;
  logic                              sda;
  logic                              cfg_we;
  logic [i3c_ctrl_pkg::CfgAddrW-1:0] cfg_addr;
  logic [i3c_ctrl_pkg::CfgDataW-1:0] cfg_wdata;
  logic                              sda_out;
  logic                              bus_start;
  logic                              bus_rstart;
  logic                              bus_stop;
  logic [7:0]                        bus_addr;
  logic                              bus_addr_valid;

  int unsigned                       cycle_cnt;
  int unsigned                       start_cnt;
  int unsigned                       rstart_cnt;
  int unsigned                       stop_cnt;
  logic [7:0]                        seen_addr[$];
  logic [31:0]                       rng_state;
  logic                              en_model;
  logic [6:0]                        static_model;

  controller DUT (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .scl_i            (scl),
    .sda_i            (sda),
    .cfg_we_i         (cfg_we),
    .cfg_addr_i       (cfg_addr),
    .cfg_wdata_i      (cfg_wdata),
    .sda_o            (sda_out),
    .bus_start_o      (bus_start),
    .bus_rstart_o     (bus_rstart),
    .bus_stop_o       (bus_stop),
    .bus_addr_o       (bus_addr),
    .bus_addr_valid_o (bus_addr_valid)
  );

  always #5 clk = ~clk;

  // Strobes sampled on the falling edge, away from the register updates
  always @(negedge clk) begin
    if (rst_n) begin
      if (bus_start) start_cnt++;
      if (bus_rstart) rstart_cnt++;
      if (bus_stop) stop_cnt++;
      if (bus_addr_valid) seen_addr.push_back(bus_addr);
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      stop_with_failure();
    end
  end

  task automatic stop_with_failure();
    $display("STATUS: FAIL");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
      stop_with_failure();
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // ACK rule: enabled and the upper seven bits hit the static address
  function automatic logic expect_ack(input logic [7:0] data);
    return en_model && (data[7:1] == static_model);
  endfunction

  task automatic wait_cycles(input int unsigned n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic write_reg(input logic [i3c_ctrl_pkg::CfgAddrW-1:0] addr,
                           input logic [7:0] data);
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    wait_cycles(1);
    cfg_we = 1'b0;
    if (addr == i3c_ctrl_pkg::CfgRegEnable) en_model = data[0];
    if (addr == i3c_ctrl_pkg::CfgRegStaticAddr) static_model = data[6:0];
    wait_cycles(1);
  endtask

  task automatic clear_counts();
    start_cnt  = 0;
    rstart_cnt = 0;
    stop_cnt   = 0;
    seen_addr.delete();
  endtask

  task automatic check_counts(input int unsigned exp_start, input int unsigned exp_rstart,
                              input int unsigned exp_stop, input int unsigned exp_valid);
    check_value("bus_start_o count", start_cnt, exp_start);
    check_value("bus_rstart_o count", rstart_cnt, exp_rstart);
    check_value("bus_stop_o count", stop_cnt, exp_stop);
    check_value("bus_addr_valid_o count", seen_addr.size(), exp_valid);
  endtask

  // Serves both START from idle and Sr after the ninth bit
  task automatic start_cond();
    sda = 1'b1;
    wait_cycles(phase_len);
    scl = 1'b1;
    wait_cycles(phase_len);
    sda = 1'b0;
    wait_cycles(phase_len);
    scl = 1'b0;
    wait_cycles(phase_len);
  endtask

  task automatic stop_cond();
    sda = 1'b0;
    wait_cycles(phase_len);
    scl = 1'b1;
    wait_cycles(phase_len);
    sda = 1'b1;
    wait_cycles(phase_len);
  endtask

  // One SCL pulse, sda_o sampled in the middle of the high phase
  task automatic send_bit(input logic b, output logic sda_seen);
    sda = b;
    wait_cycles(phase_len);
    scl = 1'b1;
    wait_cycles(phase_len / 2);
    sda_seen = sda_out;
    wait_cycles(phase_len / 2);
    scl = 1'b0;
    wait_cycles(phase_len);
  endtask

  task automatic send_byte(input logic [7:0] data, output logic ack_sda);
    logic seen;
    for (int i = 7; i >= 0; i--) begin
      send_bit(data[i], seen);
      check_value("sda_o", 32'(seen), 32'd1);
    end
    send_bit(1'b1, ack_sda);
  endtask

  task automatic addr_txn(input logic [7:0] data);
    logic ack_sda;
    clear_counts();
    start_cond();
    send_byte(data, ack_sda);
    stop_cond();
    check_counts(1, 0, 1, 1);
    check_value("bus_addr_o", 32'(seen_addr[0]), 32'(data));
    check_value("sda_o", 32'(ack_sda), 32'(!expect_ack(data)));
  endtask

  task automatic test_reset_state();
    check_value("sda_o", 32'(sda_out), 32'd1);
    clear_counts();
    wait_cycles(50);
    check_counts(0, 0, 0, 0);
    // Matches the reset static address, but the controller is off
    addr_txn(8'h00);
  endtask

  task automatic test_ack_match();
    write_reg(i3c_ctrl_pkg::CfgRegStaticAddr, 8'h52);
    write_reg(i3c_ctrl_pkg::CfgRegEnable, 8'h01);
    addr_txn(8'hA4);
    addr_txn(8'hA5);
    addr_txn(8'hA6);
    write_reg(i3c_ctrl_pkg::CfgRegEnable, 8'h00);
    addr_txn(8'hA4);
  endtask

  task automatic test_rstart();
    logic ack_sda;
    write_reg(i3c_ctrl_pkg::CfgRegEnable, 8'h01);
    clear_counts();
    start_cond();
    send_byte(8'h5A, ack_sda);
    check_value("sda_o", 32'(ack_sda), 32'(!expect_ack(8'h5A)));
    start_cond();
    send_byte(8'hA5, ack_sda);
    check_value("sda_o", 32'(ack_sda), 32'(!expect_ack(8'hA5)));
    stop_cond();
    check_counts(1, 1, 1, 2);
    check_value("bus_addr_o", 32'(seen_addr[0]), 32'h5A);
    check_value("bus_addr_o", 32'(seen_addr[1]), 32'hA5);
  endtask

  task automatic test_filter();
    write_reg(i3c_ctrl_pkg::CfgRegFilter, 8'h08);
    clear_counts();
    // Short glitch on SDA with SCL high
    sda = 1'b0;
    wait_cycles(4);
    sda = 1'b1;
    wait_cycles(2 * phase_len);
    check_counts(0, 0, 0, 0);
    sda = 1'b0;
    wait_cycles(phase_len);
    sda = 1'b1;
    wait_cycles(phase_len);
    check_counts(1, 0, 1, 0);
  endtask

  task automatic test_random();
    logic [31:0] r;
    logic [7:0]  data;
    for (int n = 0; n < 8; n++) begin
      rng_state = xorshift32(rng_state);
      r         = rng_state;
      data      = r[7:0];
      if (r[8]) data = {static_model, r[0]};
      write_reg(i3c_ctrl_pkg::CfgRegEnable, {7'b0, r[9] | r[10]});
      addr_txn(data);
    end
  endtask

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    scl          = 1'b1;
    sda          = 1'b1;
    cfg_we       = 1'b0;
    cfg_addr     = '0;
    cfg_wdata    = '0;
    cycle_cnt    = 0;
    rng_state    = 32'h9b20c6b4;
    en_model     = 1'b0;
    static_model = i3c_ctrl_pkg::ResetStaticAddr;
    clear_counts();
    wait_cycles(3);
    rst_n = 1'b1;
    wait_cycles(2);
    test_reset_state();
    // No match, controller still disabled
    addr_txn(8'h3C);
    test_ack_match();
    test_rstart();
    test_filter();
    test_random();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

// ==== rtl/addr_receiver.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Target address receiver
// Shifts in the address byte after START or Sr and ACKs a match
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module addr_receiver (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  bus_state_if.receiver                  bus,
  input  i3c_ctrl_pkg::cfg_t             cfg_i,
  output logic [i3c_ctrl_pkg::AddrW:0]   addr_o,
  output logic                           addr_valid_o,
  output logic                           sda_o
);

  typedef enum logic [1:0] {
    StIdle,
    StShift,
    StAck,
    StData
  } state_e;

  state_e                        state_q;
  logic [2:0]                    bit_cnt_q;
  logic                          valid_q;
  logic                          drive_q;
  logic [i3c_ctrl_pkg::AddrW:0]  shift_q;
  logic [i3c_ctrl_pkg::AddrW:0]  shift_d;
  logic [i3c_ctrl_pkg::AddrW:0]  addr_q;
  logic                          cond;
  logic                          sample;
  logic                          addr_match;

  assign cond       = bus.start || bus.rstart || bus.stop;
  assign sample     = (state_q == StShift) && bus.scl_rise && !cond;
  // MSB first
  assign shift_d    = {shift_q[i3c_ctrl_pkg::AddrW-1:0], bus.sda};
  assign addr_match = cfg_i.enable &&
                      (addr_q[i3c_ctrl_pkg::AddrW:1] == cfg_i.static_addr);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= StIdle;
      bit_cnt_q <= '0;
      valid_q   <= 1'b0;
      drive_q   <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      if (bus.start || bus.rstart) begin
        state_q   <= StShift;
        bit_cnt_q <= '0;
        drive_q   <= 1'b0;
      end else if (bus.stop) begin
        state_q <= StIdle;
        drive_q <= 1'b0;
      end else begin
        case (state_q)
          StShift: begin
            if (bus.scl_rise) begin
              bit_cnt_q <= bit_cnt_q + 1'b1;
              if (bit_cnt_q == 3'd7) begin
                valid_q <= 1'b1;
                state_q <= StAck;
              end
            end
          end
          StAck: begin
            // First fall drives the ACK, second one releases it
            if (bus.scl_fall) begin
              bit_cnt_q <= bit_cnt_q + 1'b1;
              if (bit_cnt_q[0]) begin
                drive_q <= 1'b0;
                state_q <= StData;
              end else begin
                drive_q <= addr_match;
              end
            end
          end
          default: begin
            // Idle or data, wait for the next condition
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (sample) begin
      shift_q <= shift_d;
      if (bit_cnt_q == 3'd7) begin
        addr_q <= shift_d;
      end
    end
  end

  assign addr_o       = addr_q;
  assign addr_valid_o = valid_q;
  assign sda_o        = !drive_q;

endmodule

// ==== rtl/bus_monitor.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus state monitor
// Filters SCL and SDA and reports START, Sr and STOP
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module bus_monitor (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               scl_i,
  input  logic               sda_i,
  input  i3c_ctrl_pkg::cfg_t cfg_i,
  bus_state_if.monitor       bus
);

  logic sda_rise;
  logic sda_fall;
  logic busy_q;
  logic start_q;
  logic rstart_q;
  logic stop_q;

  line_filter u_scl_filter (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .line_i        (scl_i),
    .filt_cycles_i (cfg_i.filt_cycles),
    .level_o       (bus.scl),
    .rise_o        (bus.scl_rise),
    .fall_o        (bus.scl_fall)
  );

  line_filter u_sda_filter (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .line_i        (sda_i),
    .filt_cycles_i (cfg_i.filt_cycles),
    .level_o       (bus.sda),
    .rise_o        (sda_rise),
    .fall_o        (sda_fall)
  );

  // SDA edges with SCL high are conditions, busy tells START from Sr
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q   <= 1'b0;
      start_q  <= 1'b0;
      rstart_q <= 1'b0;
      stop_q   <= 1'b0;
    end else begin
      start_q  <= sda_fall && bus.scl && !busy_q;
      rstart_q <= sda_fall && bus.scl && busy_q;
      stop_q   <= sda_rise && bus.scl;
      if (sda_fall && bus.scl) begin
        busy_q <= 1'b1;
      end else if (sda_rise && bus.scl) begin
        busy_q <= 1'b0;
      end
    end
  end

  assign bus.start  = start_q;
  assign bus.rstart = rstart_q;
  assign bus.stop   = stop_q;

endmodule

// ==== rtl/bus_state_if.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus state interface
// Filtered line levels, SCL edges and bus conditions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

interface bus_state_if;

  // Filtered levels
  logic scl;
  logic sda;

  // One-cycle strobes
  logic scl_rise;
  logic scl_fall;
  logic start;
  logic rstart;
  logic stop;

  modport monitor (output scl, sda, scl_rise, scl_fall, start, rstart, stop);

  modport receiver (input scl, sda, scl_rise, scl_fall, start, rstart, stop);

endinterface

// ==== rtl/configuration.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Configuration registers
// Enable, static address and filter length
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module configuration (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              cfg_we_i,
  input  logic [i3c_ctrl_pkg::CfgAddrW-1:0] cfg_addr_i,
  input  logic [i3c_ctrl_pkg::CfgDataW-1:0] cfg_wdata_i,
  output i3c_ctrl_pkg::cfg_t                cfg_o
);

  logic                              enable_q;
  logic [i3c_ctrl_pkg::AddrW-1:0]    static_addr_q;
  logic [i3c_ctrl_pkg::FiltCntW-1:0] filt_cycles_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      enable_q      <= 1'b0;
      static_addr_q <= i3c_ctrl_pkg::ResetStaticAddr;
      filt_cycles_q <= i3c_ctrl_pkg::ResetFiltCycles;
    end else if (cfg_we_i) begin
      // Each register keeps only its low bits
      case (cfg_addr_i)
        i3c_ctrl_pkg::CfgRegEnable: begin
          enable_q <= cfg_wdata_i[0];
        end
        i3c_ctrl_pkg::CfgRegStaticAddr: begin
          static_addr_q <= cfg_wdata_i[i3c_ctrl_pkg::AddrW-1:0];
        end
        i3c_ctrl_pkg::CfgRegFilter: begin
          filt_cycles_q <= cfg_wdata_i[i3c_ctrl_pkg::FiltCntW-1:0];
        end
        default: begin
          // Unmapped, dropped
        end
      endcase
    end
  end

  assign cfg_o.enable      = enable_q;
  assign cfg_o.static_addr = static_addr_q;
  assign cfg_o.filt_cycles = filt_cycles_q;

endmodule

// ==== rtl/controller.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// I3C target address controller
// Bus monitor, configuration and address receiver
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module controller (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              scl_i,
  input  logic                              sda_i,
  input  logic                              cfg_we_i,
  input  logic [i3c_ctrl_pkg::CfgAddrW-1:0] cfg_addr_i,
  input  logic [i3c_ctrl_pkg::CfgDataW-1:0] cfg_wdata_i,
  output logic                              sda_o,
  output logic                              bus_start_o,
  output logic                              bus_rstart_o,
  output logic                              bus_stop_o,
  output logic [i3c_ctrl_pkg::AddrW:0]      bus_addr_o,
  output logic                              bus_addr_valid_o
);

  i3c_ctrl_pkg::cfg_t cfg;
  bus_state_if        bus_if ();

  configuration u_configuration (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_o       (cfg)
  );

  bus_monitor u_bus_monitor (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .scl_i   (scl_i),
    .sda_i   (sda_i),
    .cfg_i   (cfg),
    .bus     (bus_if.monitor)
  );

  addr_receiver u_addr_receiver (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .bus          (bus_if.receiver),
    .cfg_i        (cfg),
    .addr_o       (bus_addr_o),
    .addr_valid_o (bus_addr_valid_o),
    .sda_o        (sda_o)
  );

  // Bus conditions straight from the monitor
  assign bus_start_o  = bus_if.start;
  assign bus_rstart_o = bus_if.rstart;
  assign bus_stop_o   = bus_if.stop;

endmodule

// ==== rtl/i3c_ctrl_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared definitions for the I3C target address controller
// Widths, register map, reset values and configuration struct
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package i3c_ctrl_pkg;

  // Line filter length width
  localparam int unsigned FiltCntW = 4;

  // 7-bit device address, RnW is appended on the bus
  localparam int unsigned AddrW = 7;

  // Configuration bus
  localparam int unsigned CfgAddrW = 2;
  localparam int unsigned CfgDataW = 8;

  // Register map
  localparam logic [CfgAddrW-1:0] CfgRegEnable     = 2'd0;
  localparam logic [CfgAddrW-1:0] CfgRegStaticAddr = 2'd1;
  localparam logic [CfgAddrW-1:0] CfgRegFilter     = 2'd2;

  // Values loaded at reset
  localparam logic [FiltCntW-1:0] ResetFiltCycles = 4'd2;
  localparam logic [AddrW-1:0]    ResetStaticAddr = 7'd0;

  // Live configuration, 12 bits
  typedef struct packed {
    logic                enable;
    logic [AddrW-1:0]    static_addr;
    logic [FiltCntW-1:0] filt_cycles;
  } cfg_t;

endpackage

// ==== rtl/line_filter.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Glitch filter for one bus line
// A new level is taken once it has held for the set length
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module line_filter (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              line_i,
  input  logic [i3c_ctrl_pkg::FiltCntW-1:0] filt_cycles_i,
  output logic                              level_o,
  output logic                              rise_o,
  output logic                              fall_o
);

  // One bit wider so the count can pass the largest length
  logic [i3c_ctrl_pkg::FiltCntW:0] cnt_q;
  logic                            level_q;
  logic                            rise_q;
  logic                            fall_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q   <= '0;
      level_q <= 1'b1;
      rise_q  <= 1'b0;
      fall_q  <= 1'b0;
    end else begin
      rise_q <= 1'b0;
      fall_q <= 1'b0;
      if (line_i == level_q) begin
        cnt_q <= '0;
      end else if (cnt_q > {1'b0, filt_cycles_i}) begin
        // Stable long enough
        level_q <= line_i;
        cnt_q   <= '0;
        rise_q  <= line_i;
        fall_q  <= !line_i;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  assign level_o = level_q;
  assign rise_o  = rise_q;
  assign fall_o  = fall_q;

endmodule
